// File: Bender.yml
package:
  name: commit_profiler

sources:
  - include_dirs:
      - logic
    files:
      - logic/prof_pkg.sv
      - logic/core_event_sampler.sv
      - logic/l2_occupancy_tracker.sv
      - logic/event_counter_bank.sv
      - logic/commit_profiler.sv
  - target: test
    include_dirs:
      - logic
    files:
      - tests/commit_profiler_checker.sv
      - tests/commit_profiler_tb.sv

// File: compile.f
+incdir+logic
logic/prof_pkg.sv
logic/core_event_sampler.sv
logic/l2_occupancy_tracker.sv
logic/event_counter_bank.sv
logic/commit_profiler.sv
tests/commit_profiler_checker.sv
tests/commit_profiler_tb.sv

// File: logic/commit_profiler.sv
module commit_profiler (
  input  logic                     clk_i,
  input  logic                     rst_n_i,
  input  logic                     en_i,
  input  logic                     freeze_i,
  input  logic                     instret_i,
  input  logic                     icache_yumi_i,
  input  logic                     icache_miss_i,
  input  logic                     dcache_miss_i,
  input  logic                     br_ovr_i,
  input  logic                     mispredict_i,
  input  logic                     data_haz_i,
  input  logic                     load_dep_i,
  input  logic                     struct_haz_i,
  input  logic                     mem_fwd_v_i,
  input  logic                     mem_fwd_ready_i,
  input  prof_pkg::mem_hdr_t       mem_fwd_hdr_i,
  input  logic                     mem_rev_v_i,
  input  logic                     mem_rev_ready_i,
  input  prof_pkg::mem_hdr_t       mem_rev_hdr_i,
  output prof_pkg::counter_array_t data_o,
  output logic                     instret_o,
  output prof_pkg::stall_reason_e  stall_o
);
  import prof_pkg::*;

  core_events_t core_events;
  l2_events_t   l2_events;

  core_event_sampler u_sampler (
    .clk_i         (clk_i),
    .rst_n_i       (rst_n_i),
    .instret_i     (instret_i),
    .icache_yumi_i (icache_yumi_i),
    .icache_miss_i (icache_miss_i),
    .dcache_miss_i (dcache_miss_i),
    .br_ovr_i      (br_ovr_i),
    .mispredict_i  (mispredict_i),
    .data_haz_i    (data_haz_i),
    .load_dep_i    (load_dep_i),
    .struct_haz_i  (struct_haz_i),
    .core_events_o (core_events)
  );

  l2_occupancy_tracker u_l2_tracker (
    .clk_i           (clk_i),
    .rst_n_i         (rst_n_i),
    .mem_fwd_v_i     (mem_fwd_v_i),
    .mem_fwd_ready_i (mem_fwd_ready_i),
    .mem_fwd_hdr_i   (mem_fwd_hdr_i),
    .mem_rev_v_i     (mem_rev_v_i),
    .mem_rev_ready_i (mem_rev_ready_i),
    .mem_rev_hdr_i   (mem_rev_hdr_i),
    .l2_events_o     (l2_events)
  );

  event_counter_bank u_counters (
    .clk_i         (clk_i),
    .rst_n_i       (rst_n_i),
    .en_i          (en_i),
    .freeze_i      (freeze_i),
    .core_events_i (core_events),
    .l2_events_i   (l2_events),
    .data_o        (data_o)
  );

  // Live commit status straight from the sampler
  assign instret_o = core_events.instret;
  assign stall_o   = core_events.stall;

endmodule

// File: logic/core_event_sampler.sv
module core_event_sampler (
  input  logic                   clk_i,
  input  logic                   rst_n_i,
  input  logic                   instret_i,
  input  logic                   icache_yumi_i,
  input  logic                   icache_miss_i,
  input  logic                   dcache_miss_i,
  input  logic                   br_ovr_i,
  input  logic                   mispredict_i,
  input  logic                   data_haz_i,
  input  logic                   load_dep_i,
  input  logic                   struct_haz_i,
  output prof_pkg::core_events_t core_events_o
);
  import prof_pkg::*;

  core_events_t events_d;

  always_comb begin
    events_d.instret = instret_i;
    events_d.ic_req  = icache_yumi_i;
    events_d.ic_miss = icache_miss_i;
    events_d.dc_miss = dcache_miss_i;
    // Registered miss level doubles as the previous sample
    events_d.ic_miss_start = icache_miss_i & ~core_events_o.ic_miss;
    events_d.dc_miss_start = dcache_miss_i & ~core_events_o.dc_miss;

    if (instret_i)
      events_d.stall = STALL_NONE;
    else if (icache_miss_i)
      events_d.stall = STALL_IC_MISS;
    else if (br_ovr_i)
      events_d.stall = STALL_BR_OVR;
    else if (mispredict_i)
      events_d.stall = STALL_MISPREDICT;
    else if (data_haz_i)
      events_d.stall = STALL_DATA_HAZ;
    else if (load_dep_i)
      events_d.stall = STALL_LOAD_DEP;
    else if (struct_haz_i)
      events_d.stall = STALL_STRUCT_HAZ;
    else if (dcache_miss_i)
      events_d.stall = STALL_DC_MISS;
    else
      events_d.stall = STALL_UNKNOWN;
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      core_events_o.instret       <= 1'b0;
      core_events_o.stall         <= STALL_UNKNOWN;
      core_events_o.ic_req        <= 1'b0;
      core_events_o.ic_miss_start <= 1'b0;
      core_events_o.ic_miss       <= 1'b0;
      core_events_o.dc_miss_start <= 1'b0;
      core_events_o.dc_miss       <= 1'b0;
    end else begin
      core_events_o <= events_d;
    end
  end

endmodule

// File: logic/event_counter_bank.sv
`include "prof_cfg.svh"

module event_counter_bank (
  input  logic                     clk_i,
  input  logic                     rst_n_i,
  input  logic                     en_i,
  input  logic                     freeze_i,
  input  prof_pkg::core_events_t   core_events_i,
  input  prof_pkg::l2_events_t     l2_events_i,
  output prof_pkg::counter_array_t data_o
);
  import prof_pkg::*;

  logic [`PROF_NUM_COUNTERS-1:0] inc;

  // Increment strobe per slot
  always_comb begin
    inc    = '0;
    inc[0] = 1'b1;
    inc[1] = core_events_i.instret;

    for (int i = 0; i < `PROF_NUM_STALLS; i++) begin
      inc[`PROF_STALL_BASE+i] = ~core_events_i.instret &
                                (core_events_i.stall == stall_reason_e'(i));
    end

    // L1 events
    inc[`PROF_EVENT_BASE+0] = core_events_i.ic_req;
    inc[`PROF_EVENT_BASE+1] = core_events_i.ic_miss_start;
    inc[`PROF_EVENT_BASE+2] = core_events_i.ic_miss;
    inc[`PROF_EVENT_BASE+3] = core_events_i.dc_miss_start;
    inc[`PROF_EVENT_BASE+4] = core_events_i.dc_miss;

    // L2 transactions by requester
    inc[`PROF_EVENT_BASE+5] = l2_events_i.ic_start;
    inc[`PROF_EVENT_BASE+6] = l2_events_i.dfetch_start;
    inc[`PROF_EVENT_BASE+7] = l2_events_i.devict_start;

    // L2 busy cycles
    inc[`PROF_EVENT_BASE+8]  = l2_events_i.ic_busy;
    inc[`PROF_EVENT_BASE+9]  = l2_events_i.dfetch_busy;
    inc[`PROF_EVENT_BASE+10] = l2_events_i.devict_busy;
  end

  // Freeze clears everything, even when counting is disabled
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      data_o <= '0;
    end else if (freeze_i) begin
      data_o <= '0;
    end else if (en_i) begin
      for (int i = 0; i < `PROF_NUM_COUNTERS; i++) begin
        // Wraps at the top
        if (inc[i])
          data_o[i] <= data_o[i] + counter_t'(1);
      end
    end
  end

endmodule

// File: logic/l2_occupancy_tracker.sv
`include "prof_cfg.svh"

module l2_occupancy_tracker (
  input  logic                 clk_i,
  input  logic                 rst_n_i,
  input  logic                 mem_fwd_v_i,
  input  logic                 mem_fwd_ready_i,
  input  prof_pkg::mem_hdr_t   mem_fwd_hdr_i,
  input  logic                 mem_rev_v_i,
  input  logic                 mem_rev_ready_i,
  input  prof_pkg::mem_hdr_t   mem_rev_hdr_i,
  output prof_pkg::l2_events_t l2_events_o
);
  import prof_pkg::*;

  // Final beat index for messages of one beat up to one block
  function automatic beat_cnt_t last_beat(msg_size_t size);
    int unsigned beats;
    beats = (32'd1 << size) / `PROF_FILL_BYTES;
    if (beats == 0)
      beats = 1;
    if (beats > `PROF_BLOCK_BYTES / `PROF_FILL_BYTES)
      beats = `PROF_BLOCK_BYTES / `PROF_FILL_BYTES;
    return beat_cnt_t'(beats - 1);
  endfunction

  // One-hot class with ic in bit 0, dfetch in bit 1 and devict in bit 2
  function automatic logic [2:0] req_class(mem_hdr_t hdr);
    return {hdr.requester & (hdr.op == MEM_WRITE),
            hdr.requester & (hdr.op == MEM_READ),
            ~hdr.requester};
  endfunction

  // Channel 0 is forward, channel 1 is reverse
  mem_hdr_t [1:0]  hdr;
  beat_cnt_t [1:0] cnt_q;
  logic [1:0]      beat;
  logic            first;
  logic [1:0]      last;
  logic [2:0]      set;
  logic [2:0]      clr;
  logic [2:0]      busy_q;
  logic [2:0]      busy_dly_q;
  logic [2:0]      start;

  assign hdr  = {mem_rev_hdr_i, mem_fwd_hdr_i};
  assign beat = {mem_rev_v_i & mem_rev_ready_i, mem_fwd_v_i & mem_fwd_ready_i};

  always_comb begin
    first = beat[0] & (cnt_q[0] == '0);
    for (int ch = 0; ch < 2; ch++) begin
      last[ch] = beat[ch] & (cnt_q[ch] == last_beat(hdr[ch].size));
    end
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      cnt_q <= '0;
    end else begin
      for (int ch = 0; ch < 2; ch++) begin
        if (last[ch])
          cnt_q[ch] <= '0;
        else if (beat[ch])
          cnt_q[ch] <= cnt_q[ch] + beat_cnt_t'(1);
      end
    end
  end

  assign set = {3{first}} & req_class(hdr[0]);
  assign clr = {3{last[1]}} & req_class(hdr[1]);

  // A new request takes priority over a retiring reply
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      busy_q     <= '0;
      busy_dly_q <= '0;
    end else begin
      busy_q     <= (busy_q & ~clr) | set;
      busy_dly_q <= busy_q;
    end
  end

  assign start = busy_q & ~busy_dly_q;

  assign l2_events_o.ic_start     = start[0];
  assign l2_events_o.dfetch_start = start[1];
  assign l2_events_o.devict_start = start[2];
  assign l2_events_o.ic_busy      = busy_q[0];
  assign l2_events_o.dfetch_busy  = busy_q[1];
  assign l2_events_o.devict_busy  = busy_q[2];

endmodule

// File: logic/prof_cfg.svh
`ifndef PROF_CFG_SVH
`define PROF_CFG_SVH

// Counter geometry
`define PROF_COUNTER_WIDTH 32
`define PROF_NUM_COUNTERS 21

// Memory side, bytes per beat and per block
`define PROF_FILL_BYTES 8
`define PROF_BLOCK_BYTES 64
`define PROF_BEAT_CNT_WIDTH 3
`define PROF_SIZE_WIDTH 3

// Slot layout
`define PROF_NUM_STALLS 8
`define PROF_STALL_BASE 2
`define PROF_EVENT_BASE 10

`endif

// File: logic/prof_pkg.sv
`include "prof_cfg.svh"

package prof_pkg;

  typedef logic [`PROF_COUNTER_WIDTH-1:0] counter_t;
  typedef logic [`PROF_BEAT_CNT_WIDTH-1:0] beat_cnt_t;
  typedef logic [`PROF_SIZE_WIDTH-1:0] msg_size_t;

  // Priority order, highest first
  typedef enum logic [3:0] {
    STALL_IC_MISS    = 4'd0,
    STALL_BR_OVR     = 4'd1,
    STALL_MISPREDICT = 4'd2,
    STALL_DATA_HAZ   = 4'd3,
    STALL_LOAD_DEP   = 4'd4,
    STALL_STRUCT_HAZ = 4'd5,
    STALL_DC_MISS    = 4'd6,
    STALL_UNKNOWN    = 4'd7,
    STALL_NONE       = 4'd8
  } stall_reason_e;

  typedef enum logic {
    MEM_READ  = 1'b0,
    MEM_WRITE = 1'b1
  } mem_op_e;

  // Requester 0 is the icache, 1 the dcache
  typedef struct packed {
    mem_op_e   op;
    logic      requester;
    msg_size_t size;
  } mem_hdr_t;

  typedef struct packed {
    logic          instret;
    stall_reason_e stall;
    logic          ic_req;
    logic          ic_miss_start;
    logic          ic_miss;
    logic          dc_miss_start;
    logic          dc_miss;
  } core_events_t;

  typedef struct packed {
    logic ic_start;
    logic dfetch_start;
    logic devict_start;
    logic ic_busy;
    logic dfetch_busy;
    logic devict_busy;
  } l2_events_t;

  typedef counter_t [`PROF_NUM_COUNTERS-1:0] counter_array_t;

endpackage

// File: tests/commit_profiler_checker.sv
module commit_profiler_checker (
  input logic                     clk_i,
  input logic                     rst_n_i,
  input logic                     freeze_i,
  input logic                     instret_i,
  input prof_pkg::stall_reason_e  stall_i,
  input prof_pkg::counter_array_t data_i
);
  import prof_pkg::*;

  a_retire_matches_stall: assert property (
    @(posedge clk_i) disable iff (!rst_n_i) instret_i == (stall_i == STALL_NONE)
  ) else $error("instret_o and stall_o disagree");

  // Cycle slot restarts from zero
  a_freeze_clears: assert property (
    @(posedge clk_i) disable iff (!rst_n_i) freeze_i |=> data_i[0] == '0
  ) else $error("cycle counter not cleared by freeze");

  a_reset_clears: assert property (
    @(posedge clk_i) $rose(rst_n_i) |-> data_i == '0
  ) else $error("counters not zero after reset");

endmodule

bind commit_profiler commit_profiler_checker u_checker (
  .clk_i     (clk_i),
  .rst_n_i   (rst_n_i),
  .freeze_i  (freeze_i),
  .instret_i (instret_o),
  .stall_i   (stall_o),
  .data_i    (data_o)
);

// File: tests/commit_profiler_stimulus.txt
# D rep en fz ir yu icm dcm br mp dh ld sh fv fr fh rv rr rh   (hex, hdr = {op, req, size})
# C slot expected name    S stall instret name
D 1 0 1 0 0 0 0 0 0 0 0 0 0 0 00 0 0 00
D 3 1 0 1 0 0 0 0 0 0 0 0 0 0 00 0 0 00
D 1 1 0 0 0 1 0 1 0 1 0 0 0 0 00 0 0 00
D 2 1 0 0 0 0 0 1 1 0 1 0 0 0 00 0 0 00
D 1 1 0 0 0 0 1 0 1 0 0 1 0 0 00 0 0 00
D 1 1 0 0 0 0 0 0 0 1 1 0 0 0 00 0 0 00
D 1 1 0 0 0 0 1 0 0 0 1 1 0 0 00 0 0 00
D 2 1 0 0 0 0 1 0 0 0 0 1 0 0 00 0 0 00
D 1 1 0 0 0 0 1 0 0 0 0 0 0 0 00 0 0 00
D 2 1 0 0 0 0 0 0 0 0 0 0 0 0 00 0 0 00
D 3 0 0 0 0 0 0 0 0 0 1 1 0 0 00 0 0 00
C 0 14 cycles_since_freeze
C 1 3 retired
C 2 1 stall_ic_miss
C 3 2 stall_br_ovr
C 4 1 stall_mispredict
C 5 1 stall_data_haz
C 6 1 stall_load_dep
C 7 2 stall_struct_haz
C 8 1 stall_dc_miss
C 9 2 stall_unknown
S 4 0 en_low_stall
D 1 0 1 0 0 0 0 0 0 0 0 0 0 0 00 0 0 00
D 1 1 0 0 1 1 0 0 0 0 0 0 1 1 1e 0 0 00
D 2 1 0 0 1 1 0 0 0 0 0 0 1 0 1e 0 0 00
D 4 1 0 0 0 0 1 0 0 0 0 0 1 1 1e 0 0 00
D 3 1 0 0 0 1 0 0 0 0 0 0 1 1 1e 0 0 00
D 1 1 0 0 0 1 0 0 0 0 0 0 1 1 0b 0 0 00
D 1 1 0 0 0 1 0 0 0 0 0 0 0 0 00 1 1 0b
D 1 1 0 0 0 0 0 0 0 0 0 0 1 1 06 1 0 1b
D 1 1 0 0 0 0 0 0 0 0 0 0 1 1 06 1 1 1b
D 6 1 0 0 0 0 0 0 0 0 0 0 1 1 06 0 0 00
D 8 1 0 0 0 0 0 0 0 0 0 0 0 0 00 1 1 06
C 10 3 ic_requests
C 11 2 ic_miss_starts
C 12 8 ic_miss_cycles
C 13 1 dc_miss_starts
C 14 4 dc_miss_cycles
C 15 1 l2_ic_starts
C 16 1 l2_dfetch_starts
C 17 1 l2_devict_starts
C 18 15 l2_ic_busy
C 19 1 l2_dfetch_busy
C 20 13 l2_devict_busy
D 4 1 0 1 0 1 0 0 0 0 0 0 0 0 00 0 0 00
D 1 1 1 1 0 0 0 0 0 0 0 0 0 0 00 0 0 00
D 3 1 0 1 0 0 0 0 0 0 0 0 0 0 00 0 0 00
C 0 5 freeze_cycles
C 1 4 freeze_retired
C 12 0 freeze_ic_miss
S 8 1 retire_status

// File: tests/commit_profiler_tb.sv
module commit_profiler_tb;
  import prof_pkg::*;

  typedef struct packed {
    logic     en;
    logic     freeze;
    logic     instret;
    logic     yumi;
    logic     ic_miss;
    logic     dc_miss;
    logic     br_ovr;
    logic     mispredict;
    logic     data_haz;
    logic     load_dep;
    logic     struct_haz;
    logic     fwd_v;
    logic     fwd_ready;
    mem_hdr_t fwd_hdr;
    logic     rev_v;
    logic     rev_ready;
    mem_hdr_t rev_hdr;
  } in_vec_t;

  logic           clk_i;
  logic           rst_n_i;
  in_vec_t        vec;
  counter_array_t data;
  logic           instret;
  stall_reason_e  stall;
  stall_reason_e  snap_stall;
  logic           snap_ir;
  logic           pending;
  int             errors;
  int             checks;
  int             cycle_cnt;
  int             limit;
  int             entries;
  int             fd;
  int             rc;
  int             slot;
  int             exp_val;
  int             exp_st;
  int             exp_ir;
  int             v[18];
  string          line;
  string          tag;
  string          name;

  commit_profiler dut (
    .clk_i           (clk_i),
    .rst_n_i         (rst_n_i),
    .en_i            (vec.en),
    .freeze_i        (vec.freeze),
    .instret_i       (vec.instret),
    .icache_yumi_i   (vec.yumi),
    .icache_miss_i   (vec.ic_miss),
    .dcache_miss_i   (vec.dc_miss),
    .br_ovr_i        (vec.br_ovr),
    .mispredict_i    (vec.mispredict),
    .data_haz_i      (vec.data_haz),
    .load_dep_i      (vec.load_dep),
    .struct_haz_i    (vec.struct_haz),
    .mem_fwd_v_i     (vec.fwd_v),
    .mem_fwd_ready_i (vec.fwd_ready),
    .mem_fwd_hdr_i   (vec.fwd_hdr),
    .mem_rev_v_i     (vec.rev_v),
    .mem_rev_ready_i (vec.rev_ready),
    .mem_rev_hdr_i   (vec.rev_hdr),
    .data_o          (data),
    .instret_o       (instret),
    .stall_o         (stall)
  );

  always #4 clk_i = ~clk_i;

  always @(posedge clk_i) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt > limit) begin
      $display("Timeout: stimulus still running after %0d cycles", limit);
      $display("CHECKS FAILED");
      $finish;
    end
  end

  task automatic drive_cycles(int n, in_vec_t x);
    repeat (n) begin
      @(posedge clk_i);
      vec <= x;
    end
  endtask

  // Two flush cycles drain the pipeline, then a random gap with counting off
  task automatic settle();
    in_vec_t idle;
    idle = '0;
    idle.en = vec.en;
    @(posedge clk_i);
    vec <= idle;
    @(negedge clk_i);
    snap_stall = stall;
    snap_ir = instret;
    @(posedge clk_i);
    vec <= idle;
    idle.en = 1'b0;
    drive_cycles(1 + $urandom % 3, idle);
    @(negedge clk_i);
  endtask

  task automatic check_counter(string tname, counter_t exp, counter_t act);
    checks++;
    if (act !== exp) begin
      errors++;
      $display("[ERROR] %s: expected %0d, actual %0d", tname, exp, act);
    end
  endtask

  task automatic check_stall(string tname, stall_reason_e exp, logic exp_ret,
                             stall_reason_e act, logic act_ret);
    checks++;
    if (act !== exp || act_ret !== exp_ret) begin
      errors++;
      $display("[ERROR] %s: expected %s/%0b, actual %s/%0b", tname, exp.name(), exp_ret,
               act.name(), act_ret);
    end
  endtask

  task automatic run_file();
    while (!$feof(fd)) begin
      rc = $fgets(line, fd);
      if (rc > 0 && $sscanf(line, "%s", tag) == 1) begin
        if (tag == "D") begin
          rc = $sscanf(line, "D %d %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                       v[0], v[1], v[2], v[3], v[4], v[5], v[6], v[7], v[8], v[9],
                       v[10], v[11], v[12], v[13], v[14], v[15], v[16], v[17]);
          drive_cycles(v[0], {v[1][0], v[2][0], v[3][0], v[4][0], v[5][0], v[6][0],
                              v[7][0], v[8][0], v[9][0], v[10][0], v[11][0], v[12][0],
                              v[13][0], v[14][4:0], v[15][0], v[16][0], v[17][4:0]});
          pending = 1'b1;
        end else if (tag == "C" || tag == "S") begin
          if (pending)
            settle();
          pending = 1'b0;
          if (tag == "C") begin
            rc = $sscanf(line, "C %d %d %s", slot, exp_val, name);
            check_counter(name, counter_t'(exp_val), data[slot]);
          end else begin
            rc = $sscanf(line, "S %d %d %s", exp_st, exp_ir, name);
            check_stall(name, stall_reason_e'(exp_st), exp_ir[0], snap_stall, snap_ir);
          end
        end
      end
    end
  endtask

  initial begin
    clk_i = 1'b0;
    rst_n_i = 1'b0;
    vec = '0;
    pending = 1'b0;
    errors = 0;
    checks = 0;
    cycle_cnt = 0;
    limit = 0;
    entries = 0;
    void'($urandom(85));
    fd = $fopen("tests/commit_profiler_stimulus.txt", "r");
    if (fd == 0) begin
      $display("Could not open the stimulus file");
      $display("CHECKS FAILED");
      $finish;
    end else begin
      // First pass sizes the timeout
      while (!$feof(fd)) begin
        rc = $fgets(line, fd);
        if (rc > 0 && $sscanf(line, "%s", tag) == 1 && tag != "#") begin
          entries++;
          if (tag == "D" && $sscanf(line, "D %d", v[0]) == 1)
            limit += v[0];
        end
      end
      $fclose(fd);
      limit = entries * 4 + limit + 100;
      fd = $fopen("tests/commit_profiler_stimulus.txt", "r");
      repeat (2) @(posedge clk_i);
      rst_n_i <= 1'b1;
      run_file();
      $fclose(fd);
      $display("Summary: %0d checks, %0d errors", checks, errors);
      if (errors == 0)
        $display("ALL CHECKS PASSED");
      else
        $display("CHECKS FAILED");
      $finish;
    end
  end

endmodule
